// ==== src/armPkg.sv ====
package armPkg;

   typedef logic [31:0] word_t;     // Data word, address or instruction
   typedef logic [3:0]  regAddr_t;
   typedef logic [3:0]  cond_t;

   localparam regAddr_t regNum       = 4'd15;  // Register that reads as PC+8
   localparam word_t    pcReadOffset = 32'd8;

   typedef struct packed {
      logic neg;
      logic zero;
      logic carry;
      logic overflow;
   } flags_t;

   typedef enum logic [1:0] {
      aluAdd = 2'b00,
      aluSub = 2'b01,
      aluAnd = 2'b10,
      aluOrr = 2'b11
   } aluOp_t;

   // Operand source in execute
   typedef enum logic [1:0] {
      fwdReg = 2'b00,
      fwdWb  = 2'b01,
      fwdMem = 2'b10
   } fwdSel_t;

   typedef struct packed {
      logic   aluSrcImm;
      aluOp_t aluOp;
      logic   flagWriteAll;    // N and Z
      logic   flagWriteArith;  // C and V
      logic   regWrite;
      logic   memWrite;
      logic   memToReg;
      logic   branch;
   } decodeCtrl_t;

   // Execute stage register
   typedef struct packed {
      decodeCtrl_t ctrl;
      cond_t       cond;
      word_t       rd1;
      word_t       rd2;
      word_t       imm;
      regAddr_t    src1;
      regAddr_t    src2;
      regAddr_t    dest;
   } exeStage_t;

   // Memory stage register, controls already condition gated
   typedef struct packed {
      logic     regWrite;
      logic     memWrite;
      logic     memToReg;
      word_t    aluResult;
      word_t    writeData;
      regAddr_t dest;
   } memStage_t;

   typedef struct packed {
      logic     regWrite;
      logic     memToReg;
      word_t    aluResult;
      word_t    readData;
      regAddr_t dest;
   } wbStage_t;

endpackage

// ==== src/armDecoder.sv ====
`timescale 1ns/1ps

module armDecoder (
   input  armPkg::word_t       instr,
   input  logic                valid,
   output armPkg::decodeCtrl_t ctrl,
   output armPkg::word_t       extImm,
   output armPkg::regAddr_t    readReg1,
   output armPkg::regAddr_t    readReg2
);
   import armPkg::*;

   logic [1:0] op;
   logic [5:0] funct;
   aluOp_t     dpOp;
   logic       dpKnown;
   logic       dpForm;
   logic       memForm;
   logic       brForm;

   assign op    = instr[27:26];
   assign funct = instr[25:20];

   always_comb begin
      dpKnown = 1'b1;
      case (funct[4:1])
         4'b0100: dpOp = aluAdd;
         4'b0010: dpOp = aluSub;
         4'b0000: dpOp = aluAnd;
         4'b1100: dpOp = aluOrr;
         default: begin
            dpOp    = aluAdd;
            dpKnown = 1'b0;
         end
      endcase
   end

   // No rotate, no shifted register, no write to R15
   assign dpForm = (op == 2'b00) && dpKnown && (instr[11:8] == 4'b0000) &&
                   (funct[5] || instr[7:4] == 4'b0000) && (instr[15:12] != regNum);
   // Immediate offset, pre-indexed, up, word, no writeback
   assign memForm = (op == 2'b01) && (funct[5:1] == 5'b01100) &&
                    !(funct[0] && instr[15:12] == regNum);
   assign brForm = (op == 2'b10) && (funct[5:4] == 2'b10);  // B without link

   always_comb begin
      ctrl = '0;  // Bubble or unsupported encoding
      if (valid) begin
         if (dpForm) begin
            ctrl.aluSrcImm      = funct[5];
            ctrl.aluOp          = dpOp;
            ctrl.flagWriteAll   = funct[0];
            ctrl.flagWriteArith = funct[0] && (dpOp == aluAdd || dpOp == aluSub);
            ctrl.regWrite       = 1'b1;
         end else if (memForm) begin
            ctrl.aluSrcImm = 1'b1;
            ctrl.regWrite  = funct[0];  // L bit
            ctrl.memToReg  = funct[0];
            ctrl.memWrite  = !funct[0];
         end else if (brForm) begin
            ctrl.aluSrcImm = 1'b1;
            ctrl.branch    = 1'b1;
         end
      end
   end

   always_comb begin
      case (op)
         2'b00:   extImm = {24'b0, instr[7:0]};
         2'b01:   extImm = {20'b0, instr[11:0]};
         default: extImm = {{6{instr[23]}}, instr[23:0], 2'b00};  // Word offset
      endcase
   end

   assign readReg1 = (op == 2'b10) ? regNum : instr[19:16];  // Branch base is PC+8
   assign readReg2 = (op == 2'b01) ? instr[15:12] : instr[3:0];  // Store data is Rd

endmodule

// ==== src/regFile.sv ====
`timescale 1ns/1ps

module regFile (
   input  logic             clk,
   input  logic             writeEn,
   input  armPkg::regAddr_t readReg1,
   input  armPkg::regAddr_t readReg2,
   input  armPkg::regAddr_t writeReg,
   input  armPkg::word_t    writeData,
   input  armPkg::word_t    pcPlus8,
   output armPkg::word_t    readData1,
   output armPkg::word_t    readData2
);
   import armPkg::*;

   word_t regs [0:14];  // R0 to R14

   // Mid-cycle write so decode sees the writeback value in the same cycle
   always_ff @(negedge clk) begin
      if (writeEn && writeReg != regNum) begin
         regs[writeReg] <= writeData;
      end
   end

   assign readData1 = (readReg1 == regNum) ? pcPlus8 : regs[readReg1];
   assign readData2 = (readReg2 == regNum) ? pcPlus8 : regs[readReg2];

endmodule

// ==== src/alu.sv ====
`timescale 1ns/1ps

module alu (
   input  armPkg::word_t  a,
   input  armPkg::word_t  b,
   input  armPkg::aluOp_t op,
   output armPkg::word_t  result,
   output armPkg::flags_t aluFlags
);
   import armPkg::*;

   logic        sub;
   logic        logicOp;
   word_t       bIn;
   logic [32:0] sum;

   assign sub     = (op == aluSub);
   assign logicOp = (op == aluAnd) || (op == aluOrr);
   assign bIn     = sub ? ~b : b;
   assign sum     = {1'b0, a} + {1'b0, bIn} + {32'b0, sub};  // Two's complement subtract

   always_comb begin
      case (op)
         aluAnd:  result = a & b;
         aluOrr:  result = a | b;
         default: result = sum[31:0];
      endcase
   end

   // Overflow when both adder inputs agree in sign and the sum does not
   assign aluFlags = '{neg:      result[31],
                       zero:     (result == '0),
                       carry:    !logicOp && sum[32],
                       overflow: !logicOp && (a[31] ~^ bIn[31]) && (a[31] ^ sum[31])};

endmodule

// ==== src/condUnit.sv ====
`timescale 1ns/1ps

module condUnit (
   input  logic           clk,
   input  logic           reset,
   input  armPkg::cond_t  cond,
   input  armPkg::flags_t aluFlags,
   input  logic           flagWriteAll,
   input  logic           flagWriteArith,
   output logic           condPass
);
   import armPkg::*;

   flags_t flags;
   flags_t flagsNext;
   logic   ge;

   assign ge = (flags.neg == flags.overflow);

   always_comb begin
      case (cond)
         4'b0000: condPass = flags.zero;                  // EQ
         4'b0001: condPass = !flags.zero;                 // NE
         4'b0010: condPass = flags.carry;                 // CS
         4'b0011: condPass = !flags.carry;                // CC
         4'b0100: condPass = flags.neg;                   // MI
         4'b0101: condPass = !flags.neg;                  // PL
         4'b0110: condPass = flags.overflow;              // VS
         4'b0111: condPass = !flags.overflow;             // VC
         4'b1000: condPass = flags.carry && !flags.zero;  // HI
         4'b1001: condPass = !flags.carry || flags.zero;  // LS
         4'b1010: condPass = ge;
         4'b1011: condPass = !ge;
         4'b1100: condPass = ge && !flags.zero;           // GT
         4'b1101: condPass = !ge || flags.zero;           // LE
         4'b1110: condPass = 1'b1;                        // AL
         default: condPass = 1'b0;
      endcase
   end

   always_comb begin
      flagsNext = flags;
      if (condPass && flagWriteAll) begin
         flagsNext.neg  = aluFlags.neg;
         flagsNext.zero = aluFlags.zero;
      end
      // C and V only from ADDS and SUBS
      if (condPass && flagWriteArith) begin
         flagsNext.carry    = aluFlags.carry;
         flagsNext.overflow = aluFlags.overflow;
      end
   end

   always_ff @(posedge clk, posedge reset) begin
      if (reset) begin
         flags <= '0;
      end else begin
         flags <= flagsNext;
      end
   end

endmodule

// ==== src/hazardUnit.sv ====
`timescale 1ns/1ps

module hazardUnit (
   input  armPkg::regAddr_t src1E,
   input  armPkg::regAddr_t src2E,
   input  armPkg::regAddr_t src1D,
   input  armPkg::regAddr_t src2D,
   input  armPkg::regAddr_t destE,
   input  armPkg::regAddr_t destM,
   input  armPkg::regAddr_t destW,
   input  logic             regWriteM,
   input  logic             regWriteW,
   input  logic             memToRegE,
   input  logic             branchTakenE,
   output armPkg::fwdSel_t  fwdA,
   output armPkg::fwdSel_t  fwdB,
   output logic             stallF,
   output logic             stallD,
   output logic             flushD,
   output logic             flushE
);
   import armPkg::*;

   logic loadUse;

   // Memory stage is younger, so it wins over writeback
   always_comb begin
      if (regWriteM && destM == src1E)      fwdA = fwdMem;
      else if (regWriteW && destW == src1E) fwdA = fwdWb;
      else                                  fwdA = fwdReg;

      if (regWriteM && destM == src2E)      fwdB = fwdMem;
      else if (regWriteW && destW == src2E) fwdB = fwdWb;
      else                                  fwdB = fwdReg;
   end

   // Load data not ready until writeback
   assign loadUse = memToRegE && (destE == src1D || destE == src2D);

   assign stallF = loadUse;
   assign stallD = loadUse;
   assign flushE = loadUse || branchTakenE;  // Bubble into execute
   assign flushD = branchTakenE;

endmodule

// ==== src/armPipeline.sv ====
`timescale 1ns/1ps

module armPipeline #(
   parameter armPkg::word_t resetVector = 32'h0000_0000
) (
   input  logic          clk,
   input  logic          reset,
   output armPkg::word_t pcF,
   input  armPkg::word_t instrF,
   output logic          memWrite,
   output armPkg::word_t dataAdr,
   output armPkg::word_t writeData,
   input  armPkg::word_t readData
);
   import armPkg::*;

   word_t       pcPlus4F;
   word_t       pcNextF;
   word_t       instrD;
   word_t       pcD;
   logic        validD;
   decodeCtrl_t ctrlD;
   word_t       extImmD;
   word_t       rd1D;
   word_t       rd2D;
   regAddr_t    readReg1D;
   regAddr_t    readReg2D;
   exeStage_t   exeNext;
   exeStage_t   exeReg;
   memStage_t   memReg;
   wbStage_t    wbReg;
   word_t       srcAE;
   word_t       writeDataE;
   word_t       srcBE;
   word_t       aluResultE;
   flags_t      aluFlagsE;
   logic        condPassE;
   logic        branchTakenE;
   word_t       resultW;
   fwdSel_t     fwdA;
   fwdSel_t     fwdB;
   logic        stallF;
   logic        stallD;
   logic        flushD;
   logic        flushE;

   function automatic word_t forward(input fwdSel_t sel, input word_t regVal,
                                     input word_t memVal, input word_t wbVal);
      case (sel)
         fwdMem:  return memVal;
         fwdWb:   return wbVal;
         default: return regVal;
      endcase
   endfunction

   // Fetch
   assign pcPlus4F = pcF + 32'd4;
   assign pcNextF  = branchTakenE ? aluResultE : pcPlus4F;  // Branch target from ALU

   always_ff @(posedge clk, posedge reset) begin
      if (reset) begin
         pcF <= resetVector;
      end else if (!stallF) begin
         pcF <= pcNextF;
      end
   end

   // Decode register
   always_ff @(posedge clk, posedge reset) begin
      if (reset) begin
         validD <= 1'b0;
      end else if (flushD) begin
         validD <= 1'b0;  // Wrong-path slot
      end else if (!stallD) begin
         validD <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!stallD) begin
         instrD <= instrF;
         pcD    <= pcF;
      end
   end

   armDecoder uDecoder (
      .instr    (instrD),
      .valid    (validD),
      .ctrl     (ctrlD),
      .extImm   (extImmD),
      .readReg1 (readReg1D),
      .readReg2 (readReg2D)
   );

   regFile uRegFile (
      .clk       (clk),
      .writeEn   (wbReg.regWrite),
      .readReg1  (readReg1D),
      .readReg2  (readReg2D),
      .writeReg  (wbReg.dest),
      .writeData (resultW),
      .pcPlus8   (pcD + pcReadOffset),
      .readData1 (rd1D),
      .readData2 (rd2D)
   );

   // Execute register
   always_comb begin
      exeNext.ctrl = flushE ? '0 : ctrlD;
      exeNext.cond = instrD[31:28];
      exeNext.rd1  = rd1D;
      exeNext.rd2  = rd2D;
      exeNext.imm  = extImmD;
      exeNext.src1 = readReg1D;
      exeNext.src2 = readReg2D;
      exeNext.dest = instrD[15:12];
   end

   always_ff @(posedge clk, posedge reset) begin
      if (reset) begin
         exeReg <= '0;
      end else begin
         exeReg <= exeNext;
      end
   end

   assign srcAE      = forward(fwdA, exeReg.rd1, memReg.aluResult, resultW);
   assign writeDataE = forward(fwdB, exeReg.rd2, memReg.aluResult, resultW);
   assign srcBE      = exeReg.ctrl.aluSrcImm ? exeReg.imm : writeDataE;

   alu uAlu (
      .a        (srcAE),
      .b        (srcBE),
      .op       (exeReg.ctrl.aluOp),
      .result   (aluResultE),
      .aluFlags (aluFlagsE)
   );

   condUnit uCondUnit (
      .clk            (clk),
      .reset          (reset),
      .cond           (exeReg.cond),
      .aluFlags       (aluFlagsE),
      .flagWriteAll   (exeReg.ctrl.flagWriteAll),
      .flagWriteArith (exeReg.ctrl.flagWriteArith),
      .condPass       (condPassE)
   );

   assign branchTakenE = exeReg.ctrl.branch && condPassE;

   // Memory register
   always_ff @(posedge clk, posedge reset) begin
      if (reset) begin
         memReg <= '0;
      end else begin
         memReg <= '{regWrite:  exeReg.ctrl.regWrite && condPassE,
                     memWrite:  exeReg.ctrl.memWrite && condPassE,
                     memToReg:  exeReg.ctrl.memToReg,
                     aluResult: aluResultE,
                     writeData: writeDataE,
                     dest:      exeReg.dest};
      end
   end

   assign memWrite  = memReg.memWrite;
   assign dataAdr   = memReg.aluResult;
   assign writeData = memReg.writeData;

   // Writeback register
   always_ff @(posedge clk, posedge reset) begin
      if (reset) begin
         wbReg <= '0;
      end else begin
         wbReg <= '{regWrite:  memReg.regWrite,
                    memToReg:  memReg.memToReg,
                    aluResult: memReg.aluResult,
                    readData:  readData,
                    dest:      memReg.dest};
      end
   end

   assign resultW = wbReg.memToReg ? wbReg.readData : wbReg.aluResult;

   hazardUnit uHazardUnit (
      .src1E        (exeReg.src1),
      .src2E        (exeReg.src2),
      .src1D        (readReg1D),
      .src2D        (readReg2D),
      .destE        (exeReg.dest),
      .destM        (memReg.dest),
      .destW        (wbReg.dest),
      .regWriteM    (memReg.regWrite),
      .regWriteW    (wbReg.regWrite),
      .memToRegE    (exeReg.ctrl.memToReg),
      .branchTakenE (branchTakenE),
      .fwdA         (fwdA),
      .fwdB         (fwdB),
      .stallF       (stallF),
      .stallD       (stallD),
      .flushD       (flushD),
      .flushE       (flushE)
   );

endmodule

// ==== bench/armPrograms.svh ====
`ifndef ARM_PROGRAMS_SVH
`define ARM_PROGRAMS_SVH

localparam cond_t condEq = 4'h0;
localparam cond_t condNe = 4'h1;
localparam cond_t condVs = 4'h6;
localparam cond_t condVc = 4'h7;
localparam cond_t condAl = 4'hE;

localparam logic [3:0] opcAnd = 4'b0000;
localparam logic [3:0] opcSub = 4'b0010;
localparam logic [3:0] opcAdd = 4'b0100;
localparam logic [3:0] opcOrr = 4'b1100;

localparam word_t overflowSrc = 32'h7FFF_FFF0;  // Plus 0x20 crosses into the sign bit

function automatic word_t encodeDpImm(input cond_t cond, input logic [3:0] opc, input logic s,
                                      input regAddr_t rn, input regAddr_t rd,
                                      input logic [7:0] imm8);
   return {cond, 3'b001, opc, s, rn, rd, 4'b0000, imm8};
endfunction

function automatic word_t encodeDpReg(input cond_t cond, input logic [3:0] opc, input logic s,
                                      input regAddr_t rn, input regAddr_t rd,
                                      input regAddr_t rm);
   return {cond, 3'b000, opc, s, rn, rd, 8'h00, rm};
endfunction

// Pre-indexed, up, word, no writeback
function automatic word_t encodeMem(input cond_t cond, input logic load, input regAddr_t rn,
                                    input regAddr_t rd, input logic [11:0] off12);
   return {cond, 3'b010, 4'b1100, load, rn, rd, off12};
endfunction

function automatic word_t encodeBranch(input cond_t cond, input logic [23:0] off24);
   return {cond, 4'b1010, off24};
endfunction

task automatic loadProgram();
   for (int i = 0; i < memWords; i++) begin
      progMem[i] = {4'hF, 28'(i)};  // NV condition, never executes
   end
   progMem[0]  = encodeDpImm(condAl, opcAnd, 1'b0, 4'd0, 4'd0, 8'h00);   // R0 = 0
   progMem[1]  = encodeDpImm(condAl, opcAdd, 1'b0, 4'd0, 4'd1, 8'h25);   // R1 = 0x25
   progMem[2]  = encodeMem(condAl, 1'b0, 4'd0, 4'd1, 12'h080);
   progMem[3]  = encodeDpImm(condAl, opcSub, 1'b0, 4'd1, 4'd2, 8'h05);   // R2 = 0x20
   progMem[4]  = encodeMem(condAl, 1'b0, 4'd0, 4'd2, 12'h084);
   progMem[5]  = encodeDpImm(condAl, opcOrr, 1'b0, 4'd1, 4'd3, 8'h50);   // R3 = 0x75
   progMem[6]  = encodeMem(condAl, 1'b0, 4'd0, 4'd3, 12'h088);
   progMem[7]  = encodeDpImm(condAl, opcAnd, 1'b0, 4'd3, 4'd4, 8'h3C);   // R4 = 0x34
   progMem[8]  = encodeMem(condAl, 1'b0, 4'd0, 4'd4, 12'h08C);
   // Register operands back to back
   progMem[9]  = encodeDpReg(condAl, opcAdd, 1'b0, 4'd3, 4'd5, 4'd4);    // R5 = 0xA9
   progMem[10] = encodeDpReg(condAl, opcSub, 1'b0, 4'd5, 4'd6, 4'd1);    // R6 = 0x84
   progMem[11] = encodeDpReg(condAl, opcAnd, 1'b0, 4'd6, 4'd7, 4'd5);    // R7 = 0x80
   progMem[12] = encodeDpReg(condAl, opcOrr, 1'b0, 4'd7, 4'd8, 4'd2);    // R8 = 0xA0
   progMem[13] = encodeMem(condAl, 1'b0, 4'd0, 4'd5, 12'h090);
   progMem[14] = encodeMem(condAl, 1'b0, 4'd0, 4'd6, 12'h094);
   progMem[15] = encodeMem(condAl, 1'b0, 4'd0, 4'd7, 12'h098);
   progMem[16] = encodeMem(condAl, 1'b0, 4'd0, 4'd8, 12'h09C);
   progMem[17] = encodeMem(condAl, 1'b1, 4'd0, 4'd9, 12'h020);           // LDR R9
   progMem[18] = encodeDpImm(condAl, opcAdd, 1'b0, 4'd9, 4'd10, 8'h11);  // Uses R9 at once
   progMem[19] = encodeMem(condAl, 1'b0, 4'd0, 4'd10, 12'h0A0);
   progMem[20] = encodeDpImm(condAl, opcSub, 1'b1, 4'd1, 4'd11, 8'h25);  // SUBS to zero
   progMem[21] = encodeDpImm(condEq, opcAdd, 1'b0, 4'd0, 4'd12, 8'h0E);
   progMem[22] = encodeMem(condEq, 1'b0, 4'd0, 4'd12, 12'h0A4);
   progMem[23] = encodeDpImm(condNe, opcAdd, 1'b0, 4'd0, 4'd13, 8'h0D);
   progMem[24] = encodeMem(condNe, 1'b0, 4'd0, 4'd13, 12'h0A8);          // Never stores
   progMem[25] = encodeMem(condAl, 1'b1, 4'd0, 4'd1, 12'h030);           // R1 = overflowSrc
   progMem[26] = encodeDpImm(condAl, opcAdd, 1'b1, 4'd1, 4'd2, 8'h20);   // ADDS sets V
   progMem[27] = encodeDpImm(condVs, opcAdd, 1'b0, 4'd2, 4'd3, 8'h01);
   progMem[28] = encodeDpImm(condVc, opcAdd, 1'b0, 4'd0, 4'd3, 8'h02);
   progMem[29] = encodeMem(condAl, 1'b0, 4'd0, 4'd3, 12'h0AC);
   progMem[30] = encodeBranch(condAl, 24'h000001);                       // To word 33
   progMem[31] = encodeMem(condAl, 1'b0, 4'd0, 4'd0, 12'h0B0);
   progMem[32] = encodeMem(condAl, 1'b0, 4'd0, 4'd1, 12'h0B4);
   progMem[33] = encodeDpImm(condAl, opcAnd, 1'b1, 4'd0, 4'd4, 8'h0F);   // Z set
   progMem[34] = encodeBranch(condNe, 24'h000004);                       // Not taken
   progMem[35] = encodeMem(condAl, 1'b0, 4'd15, 4'd1, 12'h024);          // 0x8C + 8 + 0x24
   progMem[36] = encodeBranch(condAl, 24'hFFFFFE);                       // Branch to itself
   dataMem[12] = overflowSrc;  // Byte address 0x30
endtask

task automatic loadExpectedStores();
   expectStore("arithmetic ADD imm", 32'h80, 32'h25);
   expectStore("arithmetic SUB imm", 32'h84, 32'h20);
   expectStore("arithmetic ORR imm", 32'h88, 32'h75);
   expectStore("arithmetic AND imm", 32'h8C, 32'h34);
   expectStore("arithmetic ADD reg", 32'h90, 32'hA9);
   expectStore("arithmetic SUB reg", 32'h94, 32'h84);
   expectStore("arithmetic AND reg", 32'h98, 32'h80);
   expectStore("arithmetic ORR reg", 32'h9C, 32'hA0);
   expectStore("load use", 32'hA0, dataMem[8] + 32'h11);  // Random word at 0x20
   expectStore("flags EQ", 32'hA4, 32'h0E);
   expectStore("flags VS", 32'hAC, 32'h8000_0011);
   expectStore("branch R15 base", 32'hB8, overflowSrc);
endtask

`endif

// ==== bench/armPipelineTb.sv ====
`timescale 1ns/1ps

module armPipelineTb;
   import armPkg::*;

   localparam word_t resetAddr    = 32'h0000_0000;
   localparam int    memWords     = 64;
   localparam int    maxStores    = 16;
   localparam int    storeTimeout = 500;  // Cycles
   localparam int    drainCycles  = 12;

   logic  clk = 1'b0;
   logic  reset;
   word_t pcF;
   word_t instrF;
   logic  memWrite;
   word_t dataAdr;
   word_t writeData;
   word_t readData;

   word_t progMem [0:memWords-1];
   word_t dataMem [0:memWords-1];

   // Expected stores in program order
   string expName [0:maxStores-1];
   word_t expAdr  [0:maxStores-1];
   word_t expData [0:maxStores-1];
   int    expCount = 0;
   int    storeIdx = 0;

   task automatic reportFailure(input string msg);
      $display("%s", msg);
      $display("Test failures found");
      $fatal(1);
   endtask

   task automatic expectStore(input string name, input word_t adr, input word_t data);
      expName[expCount] = name;
      expAdr[expCount]  = adr;
      expData[expCount] = data;
      expCount++;
   endtask

   task automatic fillDataMem();
      for (int i = 0; i < memWords; i++) begin
         dataMem[i] = $urandom;
      end
   endtask

   `include "armPrograms.svh"

   armPipeline #(.resetVector(resetAddr)) u_dut (
      .clk       (clk),
      .reset     (reset),
      .pcF       (pcF),
      .instrF    (instrF),
      .memWrite  (memWrite),
      .dataAdr   (dataAdr),
      .writeData (writeData),
      .readData  (readData)
   );

   initial begin
      forever #10 clk = ~clk;
   end

   // Combinational memories, presented on the falling edge
   always @(negedge clk) begin
      instrF   <= progMem[pcF[7:2]];
      readData <= dataMem[dataAdr[7:2]];
   end

   // Store monitor, sees the values held through the ending cycle
   always @(posedge clk) begin
      if (!reset) begin
         assert (!$isunknown(memWrite)) else
            reportFailure("memWrite from the DUT is unknown");
         if (memWrite === 1'b1) begin
            if (storeIdx >= expCount) begin
               reportFailure($sformatf(
                  "Unexpected store of %h to %h after the last expected store",
                  writeData, dataAdr));
            end
            assert (dataAdr === expAdr[storeIdx] && writeData === expData[storeIdx]) else
               reportFailure($sformatf(
                  "Fail %s: expected adr %h data %h, actual adr %h data %h",
                  expName[storeIdx], expAdr[storeIdx], expData[storeIdx],
                  dataAdr, writeData));
            dataMem[dataAdr[7:2]] = writeData;
            storeIdx++;
         end
      end
   end

   task automatic checkResetState();
      assert (pcF === resetAddr && memWrite === 1'b0) else
         reportFailure($sformatf(
            "Fail reset: expected pcF %h memWrite 0, actual pcF %h memWrite %b",
            resetAddr, pcF, memWrite));
   endtask

   initial begin : runTests
      int cycles;
      int seed;
      reset    = 1'b1;
      instrF   = '0;
      readData = '0;
      seed     = 32'h750f;
      void'($urandom(seed));  // Single seed for the run
      fillDataMem();
      loadProgram();
      loadExpectedStores();

      repeat (5) begin
         @(negedge clk);
         checkResetState();
      end
      reset = 1'b0;
      checkResetState();  // First cycle out of reset

      // Arithmetic, load, flag and branch stores arrive through the monitor
      cycles = 0;
      while (storeIdx < expCount) begin
         @(negedge clk);
         cycles++;
         if (cycles > storeTimeout) begin
            reportFailure($sformatf("Timed out after %0d cycles with %0d of %0d stores seen",
                                    cycles, storeIdx, expCount));
         end
      end

      // Program now spins on its last branch, any stray store still gets caught
      repeat (drainCycles) @(negedge clk);
      $display("All tests passed!");
      $finish;
   end

endmodule

// ==== armPipeline.f ====
+incdir+bench
src/armPkg.sv
src/armDecoder.sv
src/regFile.sv
src/alu.sv
src/condUnit.sv
src/hazardUnit.sv
src/armPipeline.sv
bench/armPipelineTb.sv
